/* dv/xlate_model.svh */
// translation reference model
`ifndef xlate_model_svh
`define xlate_model_svh

typedef struct packed {
  eaddr_t     eaddr;
  logic       v;
  ptag_t      ptag;
  logic       miss;
  logic       uncached;
  logic [2:0] af; // instr, load, store
  logic [2:0] pf;
} result_t;

priv_t      cfg_priv  = priv_m_c;
logic       cfg_trans = 1'b0;
logic       cfg_sum   = 1'b0;
logic       cfg_uc    = 1'b0;
logic       cfg_sac   = 1'b0;
logic [7:0] cfg_dmask = 8'h01;

logic       tlb_valid [tlb_els_c] = '{default: 1'b0};
logic       tlb_giga  [tlb_els_c];
vtag_t      tlb_tag   [tlb_els_c];
pte_leaf_t  tlb_ent   [tlb_els_c];
int         fill_ptr = 0;

function automatic void apply_cfg(input cfg_addr_t a, input logic [7:0] d);
  case (a)
    cfg_priv_c:        cfg_priv  = d[1:0];
    cfg_trans_en_c:    cfg_trans = d[0];
    cfg_sum_c:         cfg_sum   = d[0];
    cfg_uncached_c:    cfg_uc    = d[0];
    cfg_sac_c:         cfg_sac   = d[0];
    cfg_domain_mask_c: cfg_dmask = d;
    default: ;
  endcase
endfunction

function automatic void store_entry(input vtag_t vt, input pte_leaf_t e, input logic giga);
  tlb_valid[fill_ptr] = 1'b1;
  tlb_tag[fill_ptr]   = vt;
  tlb_ent[fill_ptr]   = e;
  tlb_giga[fill_ptr]  = giga;
  fill_ptr = (fill_ptr + 1) % tlb_els_c; // round robin
endfunction

function automatic void clear_entries();
  foreach (tlb_valid[i]) tlb_valid[i] = 1'b0;
  fill_ptr = 0;
endfunction

function automatic result_t ref_translate(input int kind, input eaddr_t ea);
  result_t    r;
  vtag_t      vt;
  pte_leaf_t  e;
  did_t       did;
  logic       hit, uc, acc_f, ipf, dpf, wpf, odd;
  logic [2:0] req;
  vt  = ea[38:12];
  req = {kind == 0, kind == 1, kind == 2};
  odd = ea[63:39] != {25{ea[38]}};
  e   = {4'h0, 1'b0, vt}; // bare passthrough with no permissions
  hit = !cfg_trans;
  if (cfg_trans) begin
    // downward so the lowest matching slot wins
    for (int i = tlb_els_c - 1; i >= 0; i--) begin
      if (tlb_valid[i] && (tlb_giga[i] ? tlb_tag[i][26:giga_bits_c] == vt[26:giga_bits_c]
                                       : tlb_tag[i] == vt)) begin
        hit = 1'b1;
        e   = tlb_ent[i];
        if (tlb_giga[i]) e[giga_bits_c-1:0] = vt[giga_bits_c-1:0];
      end
    end
  end
  did   = e[27:25];
  uc    = (e[27:0] < dram_base_ptag_c) || (did != 3'd0);
  acc_f = !cfg_dmask[did] || (req[2] && did != 3'd0)
          || (e[sac_bit_c] && (req[2] || !cfg_sac))
          || (cfg_uc && !uc);
  ipf = !e[pte_x_c] || (cfg_priv == priv_s_c && e[pte_u_c])
        || (cfg_priv == priv_u_c && !e[pte_u_c]);
  dpf = (cfg_priv == priv_s_c && !cfg_sum && e[pte_u_c])
        || (cfg_priv == priv_u_c && !e[pte_u_c]);
  wpf = !e[pte_w_c] || !e[pte_d_c];
  r.eaddr    = ea;
  r.ptag     = e[27:0];
  r.miss     = !hit;
  r.uncached = hit && uc;
  r.af       = (hit && acc_f) ? req : 3'b000;
  r.pf       = (hit && cfg_trans) ? (req & {ipf, dpf || odd, dpf || odd || wpf}) : 3'b000;
  r.v        = hit && (r.af == 3'b000) && (r.pf == 3'b000);
  return r;
endfunction

`endif

/* dv/xlate_tb.sv */
// address translation testbench
`timescale 1ns/1ps

module xlate_tb;
  import xlate_pkg::*;

  localparam int tlb_els_c    = 8;
  localparam int max_cycles_c = 2000; // roughly four times the stimulus

  logic      clk_i        = 1'b0;
  logic      rst_n_i      = 1'b0;
  logic      cfg_v_i      = 1'b0;
  cfg_addr_t cfg_addr_i   = '0;
  logic [7:0] cfg_data_i  = '0;
  logic      flush_i      = 1'b0;
  logic      w_v_i        = 1'b0;
  vtag_t     w_vtag_i     = '0;
  pte_leaf_t w_entry_i    = '0;
  logic      w_gigapage_i = 1'b0;
  logic      r_v_i        = 1'b0;
  logic      r_instr_i    = 1'b0;
  logic      r_load_i     = 1'b0;
  logic      r_store_i    = 1'b0;
  eaddr_t    r_eaddr_i    = '0;
  logic      r_v_o, r_miss_o, r_uncached_o;
  ptag_t     r_ptag_o;
  logic      r_instr_access_fault_o, r_load_access_fault_o, r_store_access_fault_o;
  logic      r_instr_page_fault_o, r_load_page_fault_o, r_store_page_fault_o;

  `include "xlate_model.svh"

  result_t     exp_q [$];
  logic        due_q       = 1'b0;
  int          checked_cnt = 0;
  int          cycles      = 0;
  logic [31:0] lfsr_q      = 32'd65949;

  xlate_top #(
    .tlb_els_p (tlb_els_c)
  ) u_xlate_top (.*);

  always #5 clk_i = ~clk_i;

  task automatic report_fail(input string why);
    $display("%s", why);
    $display("=== FAIL ===");
    $fatal(1, "stopping at the first failure");
  endtask

  // taps 32,22,2,1
  function automatic logic lfsr_step();
    logic fb;
    fb = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
    lfsr_q = {lfsr_q[30:0], fb};
    return fb;
  endfunction

  function automatic logic [63:0] rand_bits(input int n);
    logic [63:0] v;
    v = '0;
    for (int i = 0; i < n; i++) v = {v[62:0], lfsr_step()};
    return v;
  endfunction

  function automatic eaddr_t make_addr(input vtag_t vt, input logic [11:0] off, input logic bad);
    eaddr_t ea;
    ea = {{25{vt[26]}}, vt, off};
    ea[63] = ea[63] ^ bad; // breaks the sign extension
    return ea;
  endfunction

  task automatic clear_strobes();
    cfg_v_i   <= 1'b0;
    flush_i   <= 1'b0;
    w_v_i     <= 1'b0;
    r_v_i     <= 1'b0;
    r_instr_i <= 1'b0;
    r_load_i  <= 1'b0;
    r_store_i <= 1'b0;
  endtask

  task automatic write_cfg(input cfg_addr_t a, input logic [7:0] d);
    @(posedge clk_i);
    clear_strobes();
    cfg_v_i    <= 1'b1;
    cfg_addr_i <= a;
    cfg_data_i <= d;
    apply_cfg(a, d);
  endtask

  task automatic fill_tlb(input vtag_t vt, input pte_leaf_t e, input logic giga);
    @(posedge clk_i);
    clear_strobes();
    w_v_i        <= 1'b1;
    w_vtag_i     <= vt;
    w_entry_i    <= e;
    w_gigapage_i <= giga;
    store_entry(vt, e, giga);
  endtask

  task automatic flush_tlb();
    @(posedge clk_i);
    clear_strobes();
    flush_i <= 1'b1;
    clear_entries();
  endtask

  // kind 0 fetch, 1 load, 2 store
  task automatic issue_read(input int kind, input eaddr_t ea);
    @(posedge clk_i);
    clear_strobes();
    r_v_i     <= 1'b1;
    r_instr_i <= (kind == 0);
    r_load_i  <= (kind == 1);
    r_store_i <= (kind == 2);
    r_eaddr_i <= ea;
    exp_q.push_back(ref_translate(kind, ea));
  endtask

  always @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      due_q <= 1'b0;
    end else begin
      due_q <= r_v_i; // result shows one cycle later
    end
  end

  always @(negedge clk_i) begin
    result_t want;
    result_t got;
    if (due_q) begin
      if (exp_q.size() == 0) begin
        report_fail("a result cycle came with no request outstanding");
      end else begin
        want = exp_q.pop_front();
        got  = {want.eaddr, r_v_o, (want.miss ? want.ptag : r_ptag_o), r_miss_o, r_uncached_o,
                r_instr_access_fault_o, r_load_access_fault_o, r_store_access_fault_o,
                r_instr_page_fault_o, r_load_page_fault_o, r_store_page_fault_o};
        checked_cnt++;
        assert (got == want) else report_fail($sformatf(
          "error at %0t: eaddr %h (v,ptag,miss,uc,af,pf) got %h expected %h",
          $time, want.eaddr, got[36:0], want[36:0]));
      end
    end else begin
      // idle cycle, every strobe stays low
      assert ({r_v_o, r_miss_o, r_uncached_o, r_instr_access_fault_o, r_load_access_fault_o,
               r_store_access_fault_o, r_instr_page_fault_o, r_load_page_fault_o,
               r_store_page_fault_o} == 9'd0)
        else report_fail($sformatf("error at %0t: an output strobe is high with no request",
                                   $time));
    end
  end

  always @(posedge clk_i) begin
    cycles <= cycles + 1;
    if (cycles >= max_cycles_c) begin
      report_fail($sformatf("timeout, the run went past %0d cycles", max_cycles_c));
    end
  end

  initial begin
    vtag_t tags [tlb_els_c + 2];
    vtag_t vt;
    priv_t pm;
    repeat (4) @(posedge clk_i);
    rst_n_i <= 1'b1;

    // bare mode over low and high physical pages
    repeat (24) issue_read(1, rand_bits(rand_bits(1) ? 32 : 36));

    write_cfg(cfg_trans_en_c, 8'h01);
    for (int i = 0; i < 6; i++) begin
      tags[i] = rand_bits(27);
      fill_tlb(tags[i], rand_bits(32), i >= 4); // last two are gigapages
    end
    for (int i = 0; i < 6; i++) begin
      vt = tags[i];
      if (i >= 4) vt[giga_bits_c-1:0] = rand_bits(giga_bits_c);
      issue_read(rand_bits(2) % 3, make_addr(vt, rand_bits(12), 1'b0));
      issue_read(rand_bits(2) % 3, make_addr(vt, rand_bits(12), 1'b0)); // reuse path
    end

    issue_read(1, make_addr(rand_bits(27), 12'h0, 1'b0));
    flush_tlb();
    for (int i = 0; i < 6; i++) issue_read(1, make_addr(tags[i], 12'h0, 1'b0));

    // two more fills than slots so the oldest two drop out
    for (int i = 0; i < tlb_els_c + 2; i++) begin
      tags[i] = {20'(rand_bits(20)), 7'(i)};
      fill_tlb(tags[i], {4'h7, 4'h0, 24'(rand_bits(24))}, 1'b0);
    end
    for (int i = 0; i < tlb_els_c + 2; i++) issue_read(1, make_addr(tags[i], 12'h0, 1'b0));

    // page faults
    for (int n = 0; n < 40; n++) begin
      pm = rand_bits(2);
      if (pm == 2'd2) pm = priv_m_c;
      write_cfg(cfg_priv_c, 8'(pm));
      write_cfg(cfg_sum_c, 8'(rand_bits(1)));
      vt = rand_bits(27);
      fill_tlb(vt, {4'(rand_bits(4)), 4'h0, 24'(rand_bits(24))}, 1'b0);
      issue_read(rand_bits(2) % 3, make_addr(vt, rand_bits(12), rand_bits(2) == 0));
    end

    // access faults
    write_cfg(cfg_priv_c, 8'(priv_m_c));
    for (int n = 0; n < 40; n++) begin
      write_cfg(cfg_domain_mask_c, 8'(rand_bits(8)));
      write_cfg(cfg_sac_c, 8'(rand_bits(1)));
      write_cfg(cfg_uncached_c, 8'(rand_bits(2) == 0));
      vt = rand_bits(27);
      fill_tlb(vt, {4'hf, 28'(rand_bits(28))}, 1'b0);
      issue_read(rand_bits(2) % 3, make_addr(vt, rand_bits(12), 1'b0));
    end

    @(posedge clk_i);
    clear_strobes();
    repeat (2) @(posedge clk_i);
    if (exp_q.size() == 0 && checked_cnt > 0) begin
      $display("=== PASS ===");
      $finish;
    end else begin
      report_fail("some requests never got a result checked");
    end
  end

endmodule

/* rtl/xlate_csr.sv */
// translation control registers
`timescale 1ns/1ps

module xlate_csr (
  input  logic                clk_i,
  input  logic                rst_n_i,
  input  logic                cfg_v_i,
  input  xlate_pkg::cfg_addr_t cfg_addr_i,
  input  logic [7:0]          cfg_data_i,
  output xlate_pkg::priv_t    priv_mode_o,
  output logic                trans_en_o,
  output logic                sum_o,
  output logic                uncached_mode_o,
  output logic                sac_o,
  output logic [7:0]          domain_mask_o
);
  import xlate_pkg::*;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      priv_mode_o     <= priv_m_c;
      trans_en_o      <= 1'b0;
      sum_o           <= 1'b0;
      uncached_mode_o <= 1'b0;
      sac_o           <= 1'b0;
      domain_mask_o   <= 8'h01; // only domain 0 open
    end else if (cfg_v_i) begin
      case (cfg_addr_i)
        cfg_priv_c:        priv_mode_o     <= cfg_data_i[1:0];
        cfg_trans_en_c:    trans_en_o      <= cfg_data_i[0];
        cfg_sum_c:         sum_o           <= cfg_data_i[0];
        cfg_uncached_c:    uncached_mode_o <= cfg_data_i[0];
        cfg_sac_c:         sac_o           <= cfg_data_i[0];
        cfg_domain_mask_c: domain_mask_o   <= cfg_data_i;
        default: ; // unused index
      endcase
    end
  end

endmodule

/* rtl/xlate_mmu.sv */
// mmu with tlb, pma check and fault logic
`timescale 1ns/1ps

module xlate_mmu #(
  parameter int tlb_els_p = 8
) (
  input  logic                 clk_i,
  input  logic                 rst_n_i,
  input  logic                 flush_i,
  input  xlate_pkg::priv_t     priv_mode_i,
  input  logic                 trans_en_i,
  input  logic                 sum_i,
  input  logic                 uncached_mode_i,
  input  logic                 sac_i,
  input  logic [7:0]           domain_mask_i,
  input  logic                 w_v_i,
  input  xlate_pkg::vtag_t     w_vtag_i,
  input  xlate_pkg::pte_leaf_t w_entry_i,
  input  logic                 w_gigapage_i,
  input  logic                 r_v_i,
  input  logic                 r_instr_i,
  input  logic                 r_load_i,
  input  logic                 r_store_i,
  input  xlate_pkg::eaddr_t    r_eaddr_i,
  output logic                 r_v_o,
  output xlate_pkg::ptag_t     r_ptag_o,
  output logic                 r_miss_o,
  output logic                 r_uncached_o,
  output logic                 r_instr_access_fault_o,
  output logic                 r_load_access_fault_o,
  output logic                 r_store_access_fault_o,
  output logic                 r_instr_page_fault_o,
  output logic                 r_load_page_fault_o,
  output logic                 r_store_page_fault_o
);
  import xlate_pkg::*;

  logic      r_v_r, r_instr_r, r_load_r, r_store_r;
  vtag_t     r_vtag_li, r_vtag_r, tlb_vtag_li;
  logic      noncanon, noncanon_r;
  logic      tlb_bypass, tlb_bypass_r;
  logic      tlb_v_lo, hold_v_r, tlb_v_sel, hit;
  pte_leaf_t tlb_entry_lo;
  pte_leaf_t passthrough_entry, entry_lo;
  ptag_t     ptag;
  did_t      did;
  logic      sac_bit, uncached_pma;
  logic      domain_fault, sac_fault, mode_fault, access_fault;
  logic      instr_pf, data_priv_pf, write_pf;
  logic      instr_pf_v, load_pf_v, store_pf_v, any_pf;

  assign r_vtag_li = r_eaddr_i[vaddr_width_c-1 -: $bits(vtag_t)];
  assign noncanon  = r_eaddr_i[63:vaddr_width_c]
                     != {(64 - vaddr_width_c){r_eaddr_i[vaddr_width_c-1]}};

  // skip the array on the same tag as the read just before
  assign tlb_bypass = r_v_i & r_v_r & ~w_v_i & ~flush_i & (r_vtag_li == r_vtag_r);

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      r_v_r        <= 1'b0;
      r_instr_r    <= 1'b0;
      r_load_r     <= 1'b0;
      r_store_r    <= 1'b0;
      tlb_bypass_r <= 1'b0;
    end else begin
      r_v_r        <= r_v_i;
      r_instr_r    <= r_instr_i;
      r_load_r     <= r_load_i;
      r_store_r    <= r_store_i;
      tlb_bypass_r <= tlb_bypass;
    end
  end

  always_ff @(posedge clk_i) begin
    r_vtag_r   <= r_vtag_li;
    noncanon_r <= noncanon;
  end

  assign tlb_vtag_li = w_v_i ? w_vtag_i : r_vtag_li;

  xlate_tlb #(
    .tlb_els_p (tlb_els_p)
  ) u_tlb (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .flush_i    (flush_i),
    .v_i        ((r_v_i & ~tlb_bypass) | w_v_i),
    .w_i        (w_v_i),
    .vtag_i     (tlb_vtag_li),
    .entry_i    (w_entry_i),
    .gigapage_i (w_gigapage_i),
    .v_o        (tlb_v_lo),
    .entry_o    (tlb_entry_lo)
  );

  // keeps the last lookup's hit flag for reuse
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      hold_v_r <= 1'b0;
    end else if (!tlb_bypass_r) begin
      hold_v_r <= tlb_v_lo;
    end
  end

  assign tlb_v_sel = tlb_bypass_r ? hold_v_r : tlb_v_lo;

  always_comb begin
    passthrough_entry = '0; // no permissions in bare mode
    passthrough_entry[pte_ptag_lsb_c +: $bits(ptag_t)] = ptag_t'(r_vtag_r);
  end

  assign entry_lo = trans_en_i ? tlb_entry_lo : passthrough_entry; // entry_o holds on reuse
  assign hit      = trans_en_i ? tlb_v_sel : r_v_r;

  assign ptag    = entry_lo[pte_ptag_lsb_c +: $bits(ptag_t)];
  assign did     = ptag[$bits(ptag_t)-1 -: $bits(did_t)];
  assign sac_bit = ptag[sac_bit_c];

  // pma
  assign uncached_pma = (ptag < dram_base_ptag_c) | (did != '0);

  assign domain_fault = ~domain_mask_i[did] | (r_instr_r & (did != '0));
  assign sac_fault    = sac_bit & (r_instr_r | ~sac_i);
  assign mode_fault   = uncached_mode_i & ~uncached_pma;
  assign access_fault = domain_fault | sac_fault | mode_fault;

  assign instr_pf = ~entry_lo[pte_x_c]
                    | ((priv_mode_i == priv_s_c) & entry_lo[pte_u_c])
                    | ((priv_mode_i == priv_u_c) & ~entry_lo[pte_u_c]);
  assign data_priv_pf = ((priv_mode_i == priv_s_c) & ~sum_i & entry_lo[pte_u_c])
                        | ((priv_mode_i == priv_u_c) & ~entry_lo[pte_u_c]);
  assign write_pf = ~entry_lo[pte_w_c] | ~entry_lo[pte_d_c];

  assign instr_pf_v = r_instr_r & instr_pf;
  assign load_pf_v  = r_load_r & (data_priv_pf | noncanon_r);
  assign store_pf_v = r_store_r & (data_priv_pf | write_pf | noncanon_r);
  assign any_pf     = trans_en_i & (instr_pf_v | load_pf_v | store_pf_v);

  assign r_ptag_o               = ptag;
  assign r_miss_o               = r_v_r & ~hit;
  assign r_uncached_o           = r_v_r & hit & uncached_pma;
  assign r_instr_access_fault_o = r_v_r & hit & r_instr_r & access_fault;
  assign r_load_access_fault_o  = r_v_r & hit & r_load_r & access_fault;
  assign r_store_access_fault_o = r_v_r & hit & r_store_r & access_fault;
  assign r_instr_page_fault_o   = r_v_r & hit & trans_en_i & instr_pf_v;
  assign r_load_page_fault_o    = r_v_r & hit & trans_en_i & load_pf_v;
  assign r_store_page_fault_o   = r_v_r & hit & trans_en_i & store_pf_v;
  assign r_v_o = r_v_r & hit & ~(access_fault & (r_instr_r | r_load_r | r_store_r)) & ~any_pf;

endmodule

/* rtl/xlate_pkg.sv */
// address translation shared definitions
package xlate_pkg;

  localparam int vaddr_width_c = 39;
  localparam int giga_bits_c   = 18; // low vtag bits taken from va on a gigapage

  typedef logic [63:0] eaddr_t;
  typedef logic [26:0] vtag_t;      // va[38:12]
  typedef logic [27:0] ptag_t;      // 40-bit pa
  typedef logic [31:0] pte_leaf_t;
  typedef logic [1:0]  priv_t;
  typedef logic [2:0]  did_t;
  typedef logic [2:0]  cfg_addr_t;

  // leaf entry fields
  localparam int pte_ptag_lsb_c = 0;
  localparam int pte_d_c        = 28;
  localparam int pte_w_c        = 29;
  localparam int pte_x_c        = 30;
  localparam int pte_u_c        = 31;

  localparam priv_t priv_u_c = 2'd0;
  localparam priv_t priv_s_c = 2'd1;
  localparam priv_t priv_m_c = 2'd3;

  // domain id sits in ptag[27:25] with sac right below it
  localparam int sac_bit_c = 24;

  localparam ptag_t dram_base_ptag_c = 28'h0080000; // pa 0x8000_0000

  localparam cfg_addr_t cfg_priv_c        = 3'd0;
  localparam cfg_addr_t cfg_trans_en_c    = 3'd1;
  localparam cfg_addr_t cfg_sum_c         = 3'd2;
  localparam cfg_addr_t cfg_uncached_c    = 3'd3;
  localparam cfg_addr_t cfg_sac_c         = 3'd4;
  localparam cfg_addr_t cfg_domain_mask_c = 3'd5;

endpackage

/* rtl/xlate_tlb.sv */
// fully associative tlb
`timescale 1ns/1ps

module xlate_tlb #(
  parameter int tlb_els_p = 8
) (
  input  logic                  clk_i,
  input  logic                  rst_n_i,
  input  logic                  flush_i,
  input  logic                  v_i,
  input  logic                  w_i,
  input  xlate_pkg::vtag_t      vtag_i,
  input  xlate_pkg::pte_leaf_t  entry_i,
  input  logic                  gigapage_i,
  output logic                  v_o,
  output xlate_pkg::pte_leaf_t  entry_o
);
  import xlate_pkg::*;

  localparam int ptr_width_lp = (tlb_els_p > 1) ? $clog2(tlb_els_p) : 1;
  localparam int hi_bits_lp   = $bits(vtag_t) - giga_bits_c; // gigapage compare width

  logic [tlb_els_p-1:0]    valid_r;
  logic [tlb_els_p-1:0]    giga_r;
  vtag_t                   tag_r [tlb_els_p];
  pte_leaf_t               data_r [tlb_els_p];
  logic [ptr_width_lp-1:0] fill_ptr_r;

  logic                    rd_v;
  logic                    wr_v;
  logic [tlb_els_p-1:0]    match;
  logic                    hit;
  pte_leaf_t               hit_entry;

  assign wr_v = v_i & w_i;
  assign rd_v = v_i & ~w_i & ~flush_i; // reads in a flush cycle miss

  always_comb begin
    for (int i = 0; i < tlb_els_p; i++) begin
      if (giga_r[i]) begin
        match[i] = valid_r[i]
                   & (tag_r[i][$bits(vtag_t)-1 -: hi_bits_lp]
                      == vtag_i[$bits(vtag_t)-1 -: hi_bits_lp]);
      end else begin
        match[i] = valid_r[i] & (tag_r[i] == vtag_i);
      end
    end
  end

  // walk down so the lowest matching slot is the one left standing
  always_comb begin
    hit       = 1'b0;
    hit_entry = '0;
    for (int i = tlb_els_p - 1; i >= 0; i--) begin
      if (match[i]) begin
        hit       = 1'b1;
        hit_entry = data_r[i];
        if (giga_r[i]) begin
          hit_entry[pte_ptag_lsb_c +: giga_bits_c] = vtag_i[giga_bits_c-1:0];
        end
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      valid_r    <= '0;
      fill_ptr_r <= '0;
    end else if (flush_i) begin
      valid_r    <= '0;
      fill_ptr_r <= '0;
    end else if (wr_v) begin
      valid_r[fill_ptr_r] <= 1'b1;
      if (fill_ptr_r == ptr_width_lp'(tlb_els_p - 1)) begin
        fill_ptr_r <= '0;
      end else begin
        fill_ptr_r <= fill_ptr_r + 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (wr_v && !flush_i) begin
      tag_r[fill_ptr_r]  <= vtag_i;
      data_r[fill_ptr_r] <= entry_i;
      giga_r[fill_ptr_r] <= gigapage_i;
    end
  end

  // registered read port
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      v_o <= 1'b0;
    end else begin
      v_o <= rd_v & hit;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rd_v) begin
      entry_o <= hit_entry;
    end
  end

endmodule

/* rtl/xlate_top.sv */
// address translation slice top
`timescale 1ns/1ps

module xlate_top #(
  parameter int tlb_els_p = 8
) (
  input  logic                 clk_i,
  input  logic                 rst_n_i,
  input  logic                 cfg_v_i,
  input  xlate_pkg::cfg_addr_t cfg_addr_i,
  input  logic [7:0]           cfg_data_i,
  input  logic                 flush_i,
  input  logic                 w_v_i,
  input  xlate_pkg::vtag_t     w_vtag_i,
  input  xlate_pkg::pte_leaf_t w_entry_i,
  input  logic                 w_gigapage_i,
  input  logic                 r_v_i,
  input  logic                 r_instr_i,
  input  logic                 r_load_i,
  input  logic                 r_store_i,
  input  xlate_pkg::eaddr_t    r_eaddr_i,
  output logic                 r_v_o,
  output xlate_pkg::ptag_t     r_ptag_o,
  output logic                 r_miss_o,
  output logic                 r_uncached_o,
  output logic                 r_instr_access_fault_o,
  output logic                 r_load_access_fault_o,
  output logic                 r_store_access_fault_o,
  output logic                 r_instr_page_fault_o,
  output logic                 r_load_page_fault_o,
  output logic                 r_store_page_fault_o
);
  import xlate_pkg::*;

  priv_t      priv_mode;
  logic       trans_en, sum, uncached_mode, sac;
  logic [7:0] domain_mask;

  xlate_csr u_csr (
    .clk_i           (clk_i),
    .rst_n_i         (rst_n_i),
    .cfg_v_i         (cfg_v_i),
    .cfg_addr_i      (cfg_addr_i),
    .cfg_data_i      (cfg_data_i),
    .priv_mode_o     (priv_mode),
    .trans_en_o      (trans_en),
    .sum_o           (sum),
    .uncached_mode_o (uncached_mode),
    .sac_o           (sac),
    .domain_mask_o   (domain_mask)
  );

  xlate_mmu #(
    .tlb_els_p (tlb_els_p)
  ) u_mmu (
    .clk_i                  (clk_i),
    .rst_n_i                (rst_n_i),
    .flush_i                (flush_i),
    .priv_mode_i            (priv_mode),
    .trans_en_i             (trans_en),
    .sum_i                  (sum),
    .uncached_mode_i        (uncached_mode),
    .sac_i                  (sac),
    .domain_mask_i          (domain_mask),
    .w_v_i                  (w_v_i),
    .w_vtag_i               (w_vtag_i),
    .w_entry_i              (w_entry_i),
    .w_gigapage_i           (w_gigapage_i),
    .r_v_i                  (r_v_i),
    .r_instr_i              (r_instr_i),
    .r_load_i               (r_load_i),
    .r_store_i              (r_store_i),
    .r_eaddr_i              (r_eaddr_i),
    .r_v_o                  (r_v_o),
    .r_ptag_o               (r_ptag_o),
    .r_miss_o               (r_miss_o),
    .r_uncached_o           (r_uncached_o),
    .r_instr_access_fault_o (r_instr_access_fault_o),
    .r_load_access_fault_o  (r_load_access_fault_o),
    .r_store_access_fault_o (r_store_access_fault_o),
    .r_instr_page_fault_o   (r_instr_page_fault_o),
    .r_load_page_fault_o    (r_load_page_fault_o),
    .r_store_page_fault_o   (r_store_page_fault_o)
  );

endmodule

/* xlate.f */
+incdir+dv
rtl/xlate_pkg.sv
rtl/xlate_csr.sv
rtl/xlate_tlb.sv
rtl/xlate_mmu.sv
rtl/xlate_top.sv
dv/xlate_tb.sv
